// ==== tb.f ====
+incdir+include
rtl/auc_alu_pkg.sv
rtl/auc_map_pkg.sv
rtl/auc_modmul.sv
rtl/auc_alu.sv
rtl/auc_regfile.sv
rtl/auc_final_ctrl.sv
rtl/auc_final_top.sv
dv/tb_auc_final.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the final-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_auc_final -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== dv/tb_auc_final.sv ====
// Final-stage testbench with random slot loads, a modular reference model and readback checks
`include "auc_cfg.svh"

module tb_auc_final;

    import auc_map_pkg::*;

    localparam int                     timeout_cycles = 20000;
    localparam logic [`AUC_WID-1:0]    prime          = `AUC_PRIME;
    localparam logic [2*`AUC_WID-1:0]  prime_wide     = {{`AUC_WID{1'b0}}, `AUC_PRIME};
    localparam logic [`AUC_AWID-1:0]   spare_slot     = 5'd3;  // Not touched by the sequence

    logic                clk;
    logic                rst;
    logic                start;
    logic                swap_bit;
    ram_wr_t             host_wr;
    ram_rd_t             host_rd;
    logic [`AUC_WID-1:0] host_rdata;
    logic                busy;
    logic                done;

    logic [31:0]         rng;
    string               cur_test;
    int                  n_checks = 0;
    int                  n_errors = 0;
    int                  test_chk0;
    int                  test_err0;
    logic                aborted = 1'b0;   // Set after a timeout to skip the rest
    int                  done_cnt = 0;
    int                  done_bad = 0;
    logic                busy_prev = 1'b0;

    auc_final_top u_auc_final_top
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .swap_bit   (swap_bit),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_rdata (host_rdata),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Count done pulses and flag any where busy did not just fall
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (done)
            begin
                done_cnt = done_cnt + 1;
                if (busy || !busy_prev)
                    done_bad = done_bad + 1;
            end
            busy_prev = busy;
        end
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Field element below p
    task automatic draw_elem(input logic nonzero, output logic [`AUC_WID-1:0] v);
        rng = xorshift(rng);
        while (rng >= prime || (nonzero && rng == '0))
            rng = xorshift(rng);
        v = rng;
    endtask

    function automatic logic [`AUC_WID-1:0] mulmod(input logic [`AUC_WID-1:0] a,
                                                    input logic [`AUC_WID-1:0] b);
        logic [2*`AUC_WID-1:0] prod;
        logic [2*`AUC_WID-1:0] rem;
        prod = {{`AUC_WID{1'b0}}, a} * {{`AUC_WID{1'b0}}, b};
        rem  = prod % prime_wide;
        return rem[`AUC_WID-1:0];
    endfunction

    // Right-to-left binary exponentiation
    function automatic logic [`AUC_WID-1:0] powmod(input logic [`AUC_WID-1:0] base,
                                                   input logic [`AUC_WID-1:0] e);
        logic [`AUC_WID-1:0] res;
        logic [`AUC_WID-1:0] b;
        logic [`AUC_WID-1:0] k;
        res = 1;
        b   = base;
        k   = e;
        while (k != '0)
        begin
            if (k[0])
                res = mulmod(res, b);
            b = mulmod(b, b);
            k = k >> 1;
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Checking and bookkeeping
    task automatic check(input string what, input logic [`AUC_WID-1:0] exp,
                         input logic [`AUC_WID-1:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_chk0 = n_checks;
        test_err0 = n_errors;
    endtask

    task automatic end_test();
        $display("Test %-12s %0d checks, %0d errors", cur_test,
                 n_checks - test_chk0, n_errors - test_err0);
    endtask

    ////////////////////////////////////////
    // Host port access while idle
    task automatic host_write(input logic [`AUC_AWID-1:0] addr,
                              input logic [`AUC_WID-1:0] data);
        @(posedge clk);
        host_wr.we <= 1'b1;
        host_wr.wa <= addr;
        host_wr.wd <= data;
        @(posedge clk);
        host_wr.we <= 1'b0;
    endtask

    task automatic host_read(input logic [`AUC_AWID-1:0] addr,
                             output logic [`AUC_WID-1:0] data);
        @(posedge clk);
        host_rd.ra <= addr;
        @(posedge clk);  // Registered read data
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic wait_done(output logic seen);
        int i;
        seen = 1'b0;
        for (i = 0; i < timeout_cycles && !seen; i++)
        begin
            @(negedge clk);
            seen = done;
        end
        if (!seen)
        begin
            n_errors++;
            $display("Test %s: done did not pulse within %0d cycles", cur_test, timeout_cycles);
        end
    endtask

    task automatic wait_busy(output logic seen);
        int i;
        seen = 1'b0;
        for (i = 0; i < 100 && !seen; i++)
        begin
            @(negedge clk);
            seen = busy;
        end
        if (!seen)
        begin
            n_errors++;
            $display("Test %s: busy never rose after start", cur_test);
        end
    endtask

    ////////////////////////////////////////
    // One run loads the slots, starts, waits for done and reads back against the model
    task automatic run_case(input logic [`AUC_WID-1:0] x2, input logic [`AUC_WID-1:0] z2,
                            input logic [`AUC_WID-1:0] x3, input logic [`AUC_WID-1:0] z3,
                            input logic sb, input logic poke);
        logic [`AUC_WID-1:0] ex2;
        logic [`AUC_WID-1:0] ez2;
        logic [`AUC_WID-1:0] ex3;
        logic [`AUC_WID-1:0] ez3;
        logic [`AUC_WID-1:0] exkg;
        logic [`AUC_WID-1:0] spare_val;
        logic [`AUC_WID-1:0] got;
        logic                seen;
        int                  done_before;
        int                  bad_before;

        // Swap first and then x2 times z2^(p-2)
        ex2  = sb ? x3 : x2;
        ez2  = sb ? z3 : z2;
        ex3  = sb ? x2 : x3;
        ez3  = sb ? z2 : z3;
        exkg = mulmod(ex2, powmod(ez2, prime - 2));
        draw_elem(1'b0, spare_val);

        host_write(X2, x2);
        host_write(Z2, z2);
        host_write(X3, x3);
        host_write(Z3, z3);
        host_write(PS2, prime - 2);
        if (poke)
            host_write(spare_slot, spare_val);

        done_before = done_cnt;
        bad_before  = done_bad;
        @(posedge clk);
        start    <= 1'b1;
        swap_bit <= sb;
        @(posedge clk);
        start    <= 1'b0;

        if (poke)
        begin
            wait_busy(seen);
            if (!seen)
            begin
                aborted = 1'b1;
                return;
            end
            // Second start and a host write inside the run
            @(posedge clk);
            start      <= 1'b1;
            swap_bit   <= ~sb;
            host_wr.we <= 1'b1;
            host_wr.wa <= spare_slot;
            host_wr.wd <= ~spare_val;
            @(posedge clk);
            start      <= 1'b0;
            host_wr.we <= 1'b0;
        end

        wait_done(seen);
        if (!seen)
        begin
            aborted = 1'b1;
            return;
        end

        host_read(X2, got);
        check("X2", ex2, got);
        host_read(Z2, got);
        check("Z2", ez2, got);
        host_read(X3, got);
        check("X3", ex3, got);
        host_read(Z3, got);
        check("Z3", ez3, got);
        host_read(X_KG, got);
        check("X_KG", exkg, got);
        if (poke)
        begin
            host_read(spare_slot, got);
            check("spare slot", spare_val, got);
        end
        check("busy after run", '0, `AUC_WID'(busy));
        check("done pulses", 1, `AUC_WID'(done_cnt - done_before));
        check("done without busy drop", 0, `AUC_WID'(done_bad - bad_before));
    endtask

    ////////////////////////////////////////
    // Tests
    task automatic test_reset_idle();
        logic [`AUC_WID-1:0] vals [32];
        logic [`AUC_WID-1:0] got;
        int                  a;
        begin_test("reset_idle");
        check("busy", '0, `AUC_WID'(busy));
        check("done", '0, `AUC_WID'(done));
        for (a = 0; a < 32; a++)
        begin
            draw_elem(1'b0, vals[a]);
            host_write(5'(a), vals[a]);
        end
        for (a = 0; a < 32; a++)
        begin
            host_read(5'(a), got);
            check($sformatf("slot %0d", a), vals[a], got);
        end
        check("busy still low", '0, `AUC_WID'(busy));
        end_test();
    endtask

    task automatic test_single(input string name, input logic sb, input logic poke);
        logic [`AUC_WID-1:0] x2;
        logic [`AUC_WID-1:0] z2;
        logic [`AUC_WID-1:0] x3;
        logic [`AUC_WID-1:0] z3;
        begin_test(name);
        draw_elem(1'b0, x2);
        draw_elem(1'b1, z2);
        draw_elem(1'b0, x3);
        draw_elem(1'b1, z3);
        run_case(x2, z2, x3, z3, sb, poke);
        end_test();
    endtask

    // Back-to-back runs where run 5 inverts Z2 = 1
    task automatic test_random_runs();
        logic [`AUC_WID-1:0] x2;
        logic [`AUC_WID-1:0] z2;
        logic [`AUC_WID-1:0] x3;
        logic [`AUC_WID-1:0] z3;
        logic                sb;
        int                  r;
        for (r = 0; r < 20 && !aborted; r++)
        begin
            begin_test($sformatf("random_%02d", r));
            draw_elem(1'b0, x2);
            draw_elem(1'b1, z2);
            draw_elem(1'b0, x3);
            draw_elem(1'b1, z3);
            rng = xorshift(rng);
            sb  = rng[7];
            if (r == 5)
            begin
                z2 = 1;
                sb = 1'b0;
            end
            run_case(x2, z2, x3, z3, sb, 1'b0);
            end_test();
        end
    endtask

    initial
    begin
        rst      = 1'b1;
        start    = 1'b0;
        swap_bit = 1'b0;
        host_wr  = '0;
        host_rd  = '0;
        rng      = 32'd9729;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        test_reset_idle();
        if (!aborted)
            test_single("swap_zero", 1'b0, 1'b0);
        if (!aborted)
            test_single("swap_one", 1'b1, 1'b0);
        if (!aborted)
            test_single("busy_guard", 1'b1, 1'b1);
        if (!aborted)
            test_random_runs();

        $display("Totals: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== rtl/auc_final_top.sv ====
// Final-stage top: sequencer, ALU with multiplier, register file
`include "auc_cfg.svh"

module auc_final_top
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  swap_bit,
    input  auc_map_pkg::ram_wr_t  host_wr,
    input  auc_map_pkg::ram_rd_t  host_rd,
    output logic [`AUC_WID-1:0]   host_rdata,  // Also feeds the ALU
    output logic                  busy,
    output logic                  done
);

    import auc_alu_pkg::*;
    import auc_map_pkg::*;

    alu_req_t alu_req;
    alu_rsp_t alu_rsp;
    ram_wr_t  ctrl_wr;
    ram_rd_t  ctrl_rd;

    auc_final_ctrl u_ctrl
    (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .swap_bit (swap_bit),
        .alu_rsp  (alu_rsp),
        .alu_req  (alu_req),
        .ctrl_wr  (ctrl_wr),
        .ctrl_rd  (ctrl_rd),
        .busy     (busy),
        .done     (done)
    );

    auc_alu u_alu
    (
        .clk     (clk),
        .rst     (rst),
        .alu_req (alu_req),
        .rdata   (host_rdata),
        .alu_rsp (alu_rsp)
    );

    auc_regfile u_regfile
    (
        .clk     (clk),
        .busy    (busy),
        .ctrl_wr (ctrl_wr),
        .ctrl_rd (ctrl_rd),
        .host_wr (host_wr),
        .host_rd (host_rd),
        .rdata   (host_rdata)
    );

endmodule

// ==== rtl/auc_final_ctrl.sv ====
// Final-stage sequencer: swap, Fermat inversion of Z2 and affine x result
`include "auc_cfg.svh"

module auc_final_ctrl
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   swap_bit,
    input  auc_alu_pkg::alu_rsp_t  alu_rsp,
    output auc_alu_pkg::alu_req_t  alu_req,
    output auc_map_pkg::ram_wr_t   ctrl_wr,
    output auc_map_pkg::ram_rd_t   ctrl_rd,
    output logic                   busy,
    output logic                   done
);

    import auc_alu_pkg::*;
    import auc_map_pkg::*;

    fin_state_e           state;
    fin_state_e           st_prev;     // State one cycle back, for entry detect
    logic                 is_wait;
    logic                 swap_q;      // Swap bit latched at start
    logic                 req_en;
    logic                 req_pend;    // Request issued, no vld yet
    alu_op_e              req_op;
    logic                 wr_en;
    logic [`AUC_AWID-1:0] wr_addr;
    logic [`AUC_WID-1:0]  wr_data;
    logic [`AUC_AWID-1:0] rd_addr;

    assign is_wait = state inside {F_SWAPZ3, F_SWAPX3, F_POW, F_RSLT};

    ////////////////////////////////////////
    // State sequence
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= F_IDLE;
            st_prev <= F_IDLE;
        end
        else
        begin
            st_prev <= state;
            case (state)
                F_IDLE:    if (start) state <= F_SWAPZ2;  // Start during a run is ignored
                F_SWAPZ2:  state <= F_SWAPZ3;
                F_SWAPZ3:  if (alu_rsp.vld) state <= F_SWAPZ32;
                F_SWAPZ32: state <= F_SWAPX2;
                F_SWAPX2:  state <= F_SWAPX3;
                F_SWAPX3:  if (alu_rsp.vld) state <= F_SWAPX32;
                F_SWAPX32: state <= F_SWAPX33;
                F_SWAPX33: state <= F_POW;
                F_POW:     if (alu_rsp.vld) state <= F_POW2;
                F_POW2:    state <= F_RSLT;
                F_RSLT:    if (alu_rsp.vld) state <= F_DONE;
                F_DONE:    state <= F_IDLE;
                default:   state <= F_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Control outputs, one cycle behind the state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_en   <= 1'b0;
            req_pend <= 1'b0;
            wr_en    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end
        else
        begin
            req_en <= is_wait && (state != st_prev);  // Only on entry to a wait state
            wr_en  <= state inside {F_SWAPZ32, F_SWAPX2, F_SWAPX32,
                                    F_SWAPX33, F_POW2, F_DONE};
            busy   <= (state != F_IDLE);
            // Cycle after the last X_KG write, busy drops here too
            done   <= busy && (state == F_IDLE);
            if (req_en)
                req_pend <= 1'b1;
            else if (alu_rsp.vld)
                req_pend <= 1'b0;
        end
    end

    // Addresses, opcode and write data
    always_ff @(posedge clk)
    begin
        if (start && state == F_IDLE)
            swap_q <= swap_bit;

        // Z3 and X3 take the swap partner
        wr_data <= (state == F_SWAPX2 || state == F_SWAPX33) ? alu_rsp.rswap : alu_rsp.dat;

        req_op  <= NOP;
        rd_addr <= STRAY;
        wr_addr <= STRAY;
        case (state)
            F_SWAPZ2:  rd_addr <= Z2;
            F_SWAPZ3:
            begin
                rd_addr <= Z3;
                req_op  <= SWAP;
            end
            F_SWAPZ32: wr_addr <= Z2;
            F_SWAPX2:
            begin
                wr_addr <= Z3;
                rd_addr <= X2;
            end
            F_SWAPX3:
            begin
                rd_addr <= X3;
                req_op  <= SWAP;
            end
            F_SWAPX32: wr_addr <= X2;
            F_SWAPX33:
            begin
                wr_addr <= X3;
                rd_addr <= Z2;  // Base of the inversion
            end
            F_POW:
            begin
                rd_addr <= PS2;
                req_op  <= EXP;
            end
            F_POW2:
            begin
                wr_addr <= X_KG;  // Park 1/Z2
                rd_addr <= X2;
            end
            F_RSLT:
            begin
                rd_addr <= X_KG;
                req_op  <= MUL;
            end
            F_DONE:    wr_addr <= X_KG;
            default:   ;
        endcase
    end

    assign alu_req = '{en: req_en, op: req_op, swap: swap_q};
    assign ctrl_wr = '{we: wr_en, wa: wr_addr, wd: wr_data};
    assign ctrl_rd = '{ra: rd_addr};

    ////////////////////////////////////////
    // Checks
    a_no_stray_wr: assert property (@(posedge clk) disable iff (rst)
        ctrl_wr.we |-> (ctrl_wr.wa != STRAY));

    // One request in flight at a time
    a_no_req_while_wait: assert property (@(posedge clk) disable iff (rst)
        alu_req.en |-> !req_pend);

endmodule

// ==== rtl/auc_regfile.sv ====
// 32-word register file, one write and one registered read port, sequencer/host mux
`include "auc_cfg.svh"

module auc_regfile
(
    input  logic                  clk,
    input  logic                  busy,
    input  auc_map_pkg::ram_wr_t  ctrl_wr,
    input  auc_map_pkg::ram_rd_t  ctrl_rd,
    input  auc_map_pkg::ram_wr_t  host_wr,
    input  auc_map_pkg::ram_rd_t  host_rd,
    output logic [`AUC_WID-1:0]   rdata
);

    import auc_map_pkg::*;

    logic [`AUC_WID-1:0] mem [2**`AUC_AWID];
    ram_wr_t             wr_sel;
    ram_rd_t             rd_sel;

    ////////////////////////////////////////
    // Port ownership
    // Sequencer owns the RAM while busy, host writes in that window are lost
    always_comb
    begin
        wr_sel = busy ? ctrl_wr : host_wr;
        rd_sel = busy ? ctrl_rd : host_rd;
    end

    always_ff @(posedge clk)
    begin
        if (wr_sel.we)
            mem[wr_sel.wa] <= wr_sel.wd;
        rdata <= mem[rd_sel.ra];  // Old data on same-address collision
    end

endmodule

// ==== rtl/auc_alu.sv ====
// ALU: operand capture, conditional swap, single multiply and square-and-multiply
`include "auc_cfg.svh"

module auc_alu
(
    input  logic                   clk,
    input  logic                   rst,
    input  auc_alu_pkg::alu_req_t  alu_req,
    input  logic [`AUC_WID-1:0]    rdata,
    output auc_alu_pkg::alu_rsp_t  alu_rsp
);

    import auc_alu_pkg::*;

    localparam int cnt_w = $clog2(`AUC_WID);
    localparam logic [cnt_w-1:0]    cnt_top = cnt_w'(`AUC_WID - 1);
    localparam logic [`AUC_WID-1:0] acc_one = 1;

    typedef enum logic [2:0] {A_IDLE, A_OPB, A_MUL, A_STEP, A_SQR, A_MLT} alu_state_e;

    alu_state_e          st;
    alu_op_e             op_q;
    logic                swp_q;
    logic                req_seen;
    logic [`AUC_WID-1:0] a_q;        // Operand A, also the EXP base
    logic [`AUC_WID-1:0] e_q;        // Exponent, shifted left per bit
    logic [`AUC_WID-1:0] acc;
    logic [cnt_w-1:0]    cnt;
    logic                mm_go;
    logic [`AUC_WID-1:0] mm_x;
    logic [`AUC_WID-1:0] mm_y;
    logic                mm_done;
    logic [`AUC_WID-1:0] mm_p;
    logic                rsp_vld;
    logic [`AUC_WID-1:0] rsp_dat;
    logic [`AUC_WID-1:0] rsp_rswap;

    auc_modmul u_modmul
    (
        .clk      (clk),
        .rst      (rst),
        .mm_start (mm_go),
        .mm_a     (mm_x),
        .mm_b     (mm_y),
        .mm_done  (mm_done),
        .mm_p     (mm_p)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            st       <= A_IDLE;
            rsp_vld  <= 1'b0;
            mm_go    <= 1'b0;
            req_seen <= 1'b0;
        end
        else
        begin
            rsp_vld <= 1'b0;
            mm_go   <= 1'b0;
            if (alu_req.en)
                req_seen <= 1'b1;
            else if (rsp_vld)
                req_seen <= 1'b0;

            case (st)
                A_IDLE:
                    if (alu_req.en)
                    begin
                        a_q   <= rdata;  // Operand A
                        op_q  <= alu_req.op;
                        swp_q <= alu_req.swap;
                        st    <= A_OPB;
                    end
                A_OPB:  // rdata is operand B this cycle
                    case (op_q)
                        MUL:
                        begin
                            mm_x  <= a_q;
                            mm_y  <= rdata;
                            mm_go <= 1'b1;
                            st    <= A_MUL;
                        end
                        EXP:
                        begin
                            acc <= acc_one;
                            e_q <= rdata;
                            cnt <= cnt_top;
                            st  <= A_STEP;
                        end
                        default:  // SWAP, NOP passes A
                        begin
                            rsp_dat   <= (op_q == SWAP && swp_q) ? rdata : a_q;
                            rsp_rswap <= (op_q == SWAP && swp_q) ? a_q : rdata;
                            rsp_vld   <= 1'b1;
                            st        <= A_IDLE;
                        end
                    endcase
                A_MUL:
                    if (mm_done)
                    begin
                        rsp_dat <= mm_p;
                        rsp_vld <= 1'b1;
                        st      <= A_IDLE;
                    end
                A_STEP:  // Square the accumulator
                begin
                    mm_x  <= acc;
                    mm_y  <= acc;
                    mm_go <= 1'b1;
                    st    <= A_SQR;
                end
                A_SQR:
                    if (mm_done)
                    begin
                        acc <= mm_p;
                        if (e_q[`AUC_WID-1])
                        begin
                            mm_x  <= mm_p;
                            mm_y  <= a_q;
                            mm_go <= 1'b1;
                            st    <= A_MLT;
                        end
                        else if (cnt == '0)
                        begin
                            rsp_dat <= mm_p;
                            rsp_vld <= 1'b1;
                            st      <= A_IDLE;
                        end
                        else
                        begin
                            cnt <= cnt - 1'b1;
                            e_q <= e_q << 1;
                            st  <= A_STEP;
                        end
                    end
                A_MLT:
                    if (mm_done)
                    begin
                        acc <= mm_p;
                        if (cnt == '0)  // Last exponent bit
                        begin
                            rsp_dat <= mm_p;
                            rsp_vld <= 1'b1;
                            st      <= A_IDLE;
                        end
                        else
                        begin
                            cnt <= cnt - 1'b1;
                            e_q <= e_q << 1;
                            st  <= A_STEP;
                        end
                    end
                default: st <= A_IDLE;
            endcase
        end
    end

    assign alu_rsp = '{vld: rsp_vld, dat: rsp_dat, rswap: rsp_rswap};

    a_vld_after_req: assert property (@(posedge clk) disable iff (rst)
        alu_rsp.vld |-> req_seen);

endmodule

// ==== rtl/auc_modmul.sv ====
// Iterative MSB-first double-and-add modular multiplier
`include "auc_cfg.svh"

module auc_modmul
(
    input  logic                clk,
    input  logic                rst,
    input  logic                mm_start,
    input  logic [`AUC_WID-1:0] mm_a,
    input  logic [`AUC_WID-1:0] mm_b,
    output logic                mm_done,
    output logic [`AUC_WID-1:0] mm_p
);

    localparam int cnt_w = $clog2(`AUC_WID);
    localparam logic [cnt_w-1:0]    cnt_top = cnt_w'(`AUC_WID - 1);
    localparam logic [`AUC_WID+1:0] prime_x = {2'b00, `AUC_PRIME};

    logic                run;
    logic [cnt_w-1:0]    cnt;
    logic [`AUC_WID-1:0] a_q;
    logic [`AUC_WID-1:0] b_q;       // Multiplier bits, MSB first
    logic [`AUC_WID+1:0] dbl_sum;   // 2*acc + A, below 3p
    logic [`AUC_WID+1:0] red1;
    logic [`AUC_WID+1:0] red2;

    // Operands assumed reduced below p
    always_comb
    begin
        dbl_sum = {1'b0, mm_p, 1'b0} + (b_q[`AUC_WID-1] ? {2'b00, a_q} : '0);
        red1    = (dbl_sum >= prime_x) ? dbl_sum - prime_x : dbl_sum;
        red2    = (red1 >= prime_x) ? red1 - prime_x : red1;
    end

    ////////////////////////////////////////
    // One bit per cycle, done AUC_WID+1 cycles after start
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run     <= 1'b0;
            mm_done <= 1'b0;
        end
        else
        begin
            mm_done <= 1'b0;
            if (mm_start)
            begin
                run  <= 1'b1;
                cnt  <= cnt_top;
                a_q  <= mm_a;
                b_q  <= mm_b;
                mm_p <= '0;
            end
            else if (run)
            begin
                mm_p <= red2[`AUC_WID-1:0];
                b_q  <= b_q << 1;
                cnt  <= cnt - 1'b1;
                if (cnt == '0)
                begin
                    run     <= 1'b0;
                    mm_done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/auc_map_pkg.sv ====
// Register file slot enum, final-stage state enum and RAM port structs
`include "auc_cfg.svh"

package auc_map_pkg;

    ////////////////////////////////////////
    // Slots touched by the final stage
    typedef enum logic [`AUC_AWID-1:0] {
        X2    = 5'd7,
        Z2    = 5'd8,
        X3    = 5'd9,
        Z3    = 5'd10,
        X_KG  = 5'd15,  // Affine x result
        PS2   = 5'd29,  // p-2, exponent for the inversion
        STRAY = 5'd30   // Default address, never written on purpose
    } ram_addr_e;

    // Final-stage sequence
    typedef enum logic [3:0] {
        F_IDLE, F_SWAPZ2, F_SWAPZ3, F_SWAPZ32,
        F_SWAPX2, F_SWAPX3, F_SWAPX32, F_SWAPX33,
        F_POW, F_POW2, F_RSLT, F_DONE
    } fin_state_e;

    ////////////////////////////////////////
    // RAM ports
    typedef struct packed {
        logic                 we;
        logic [`AUC_AWID-1:0] wa;
        logic [`AUC_WID-1:0]  wd;
    } ram_wr_t;

    typedef struct packed {
        logic [`AUC_AWID-1:0] ra;
    } ram_rd_t;

endpackage

// ==== rtl/auc_alu_pkg.sv ====
// ALU opcode enum, ALU request and response structs
`include "auc_cfg.svh"

package auc_alu_pkg;

    ////////////////////////////////////////
    // Opcodes issued by the final stage
    typedef enum logic [1:0] {
        NOP  = 2'd0,
        SWAP = 2'd1,   // Conditional swap of A and B
        MUL  = 2'd2,   // A*B mod p
        EXP  = 2'd3    // A^B mod p
    } alu_op_e;

    ////////////////////////////////////////
    // Sequencer to ALU
    typedef struct packed {
        logic    en;     // One-cycle start
        alu_op_e op;
        logic    swap;   // Swap bit for SWAP
    } alu_req_t;

    // ALU to sequencer
    typedef struct packed {
        logic                vld;    // One-cycle result strobe
        logic [`AUC_WID-1:0] dat;
        logic [`AUC_WID-1:0] rswap;  // Swap partner
    } alu_rsp_t;

endpackage

// ==== include/auc_cfg.svh ====
// Data width, RAM address width and field prime for the final stage
`ifndef AUC_CFG_SVH
`define AUC_CFG_SVH

// Datapath width in bits
`define AUC_WID   32

// Register file address width, 32 slots
`define AUC_AWID  5

// Field prime p = 2^32 - 5, must fit AUC_WID bits
`define AUC_PRIME 32'd4294967291

`endif
